// File: verilog/rvc_pkg.sv
// RV32C decoder shared types
// Unit-select and function codes, opcode keys, fixed register indices
package rvc_pkg;

    typedef logic [15:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] imm_t;
    typedef logic [2:0]  sel_t;
    typedef logic [3:0]  func_t;
    typedef logic [4:0]  opc_t;     // {funct3, quadrant}

    // ================================================
    // Execution unit select
    localparam sel_t SEL_NONE = 3'd0;
    localparam sel_t SEL_ALU  = 3'd1;
    localparam sel_t SEL_BJU  = 3'd2;
    localparam sel_t SEL_LSU  = 3'd3;
    localparam sel_t SEL_CP0  = 3'd4;

    // ================================================
    // Function codes
    localparam func_t FUNC_NONE   = 4'd0;
    localparam func_t FUNC_ADD    = 4'd1;
    localparam func_t FUNC_SUB    = 4'd2;
    localparam func_t FUNC_SLL    = 4'd3;
    localparam func_t FUNC_SRL    = 4'd4;
    localparam func_t FUNC_SRA    = 4'd5;
    localparam func_t FUNC_AND    = 4'd6;
    localparam func_t FUNC_OR     = 4'd7;
    localparam func_t FUNC_XOR    = 4'd8;
    localparam func_t FUNC_JAL    = 4'd9;
    localparam func_t FUNC_JALR   = 4'd10;
    localparam func_t FUNC_BEQ    = 4'd11;
    localparam func_t FUNC_BNE    = 4'd12;
    localparam func_t FUNC_LW     = 4'd13;
    localparam func_t FUNC_SW     = 4'd14;
    localparam func_t FUNC_EBREAK = 4'd15;

    // ================================================
    // Opcode keys, quadrant 0
    localparam opc_t OPC_ADDI4SPN = 5'b000_00;
    localparam opc_t OPC_LW       = 5'b010_00;
    localparam opc_t OPC_SW       = 5'b110_00;
    // Quadrant 1
    localparam opc_t OPC_ADDI     = 5'b000_01;
    localparam opc_t OPC_JAL      = 5'b001_01;
    localparam opc_t OPC_LI       = 5'b010_01;
    localparam opc_t OPC_LUI      = 5'b011_01;    // Also C.ADDI16SP
    localparam opc_t OPC_MISC_ALU = 5'b100_01;
    localparam opc_t OPC_J        = 5'b101_01;
    localparam opc_t OPC_BEQZ     = 5'b110_01;
    localparam opc_t OPC_BNEZ     = 5'b111_01;
    // Quadrant 2
    localparam opc_t OPC_SLLI     = 5'b000_10;
    localparam opc_t OPC_LWSP     = 5'b010_10;
    localparam opc_t OPC_JR_MV    = 5'b100_10;    // Also C.ADD, C.JALR, C.EBREAK
    localparam opc_t OPC_SWSP     = 5'b110_10;

    // Fixed register indices
    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_RA   = 5'd1;
    localparam reg_idx_t REG_SP   = 5'd2;

endpackage

// File: verilog/rvc_unit_decd.sv
// Execution unit and function decode for RV32C
// Also tells whether the instruction writes rd
`timescale 1ns/100ps

module rvc_unit_decd
(
    input  rvc_pkg::inst_t inst,
    output rvc_pkg::sel_t  sel,
    output rvc_pkg::func_t func,
    output logic           rd_vld
);

    rvc_pkg::opc_t opc;
    logic          rs2_zero;
    logic          rd_zero;
    // {sel, func, rd_vld} of the matched instruction
    logic [$bits(rvc_pkg::sel_t)+$bits(rvc_pkg::func_t):0] dec;

    assign opc      = {inst[15:13], inst[1:0]};
    assign rs2_zero = (inst[6:2] == 5'd0);
    assign rd_zero  = (inst[11:7] == 5'd0);

    always_comb
    begin
        dec = {rvc_pkg::SEL_NONE, rvc_pkg::FUNC_NONE, 1'b0};
        case (opc)
            // ================================================
            // ALU group
            rvc_pkg::OPC_ADDI4SPN,
            rvc_pkg::OPC_ADDI,
            rvc_pkg::OPC_LI,
            rvc_pkg::OPC_LUI:
                dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_ADD, 1'b1};
            rvc_pkg::OPC_SLLI:
                dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_SLL, 1'b1};
            rvc_pkg::OPC_MISC_ALU:
            begin
                casez ({inst[12:10], inst[6:5]})
                    5'b?00??: dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_SRL, 1'b1};
                    5'b?01??: dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_SRA, 1'b1};
                    5'b?10??: dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_AND, 1'b1}; // C.ANDI
                    5'b01100: dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_SUB, 1'b1};
                    5'b01101: dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_XOR, 1'b1};
                    5'b01110: dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_OR, 1'b1};
                    5'b01111: dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_AND, 1'b1};
                    default:  dec = {rvc_pkg::SEL_NONE, rvc_pkg::FUNC_NONE, 1'b0};
                endcase
            end
            // C.JR / C.MV split on rs2, the bit-12 half adds EBREAK
            rvc_pkg::OPC_JR_MV:
            begin
                if (!inst[12])
                    dec = rs2_zero ? {rvc_pkg::SEL_BJU, rvc_pkg::FUNC_JALR, 1'b0}
                                   : {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_ADD, 1'b1};
                else if (rs2_zero && rd_zero)
                    dec = {rvc_pkg::SEL_CP0, rvc_pkg::FUNC_EBREAK, 1'b0};
                else if (rs2_zero)
                    dec = {rvc_pkg::SEL_BJU, rvc_pkg::FUNC_JALR, 1'b1};   // C.JALR
                else
                    dec = {rvc_pkg::SEL_ALU, rvc_pkg::FUNC_ADD, 1'b1};    // C.ADD
            end
            // ================================================
            // BJU group
            rvc_pkg::OPC_JAL:  dec = {rvc_pkg::SEL_BJU, rvc_pkg::FUNC_JAL, 1'b1};
            rvc_pkg::OPC_J:    dec = {rvc_pkg::SEL_BJU, rvc_pkg::FUNC_JAL, 1'b0};
            rvc_pkg::OPC_BEQZ: dec = {rvc_pkg::SEL_BJU, rvc_pkg::FUNC_BEQ, 1'b0};
            rvc_pkg::OPC_BNEZ: dec = {rvc_pkg::SEL_BJU, rvc_pkg::FUNC_BNE, 1'b0};
            // ================================================
            // LSU group, FP forms fall to default
            rvc_pkg::OPC_LW,
            rvc_pkg::OPC_LWSP: dec = {rvc_pkg::SEL_LSU, rvc_pkg::FUNC_LW, 1'b1};
            rvc_pkg::OPC_SW,
            rvc_pkg::OPC_SWSP: dec = {rvc_pkg::SEL_LSU, rvc_pkg::FUNC_SW, 1'b0};
            default:           dec = {rvc_pkg::SEL_NONE, rvc_pkg::FUNC_NONE, 1'b0};
        endcase
    end

    assign {sel, func, rd_vld} = dec;

    // A write to rd always has a unit behind it
    a_rd_has_unit: assert property (@(inst) rd_vld |-> (sel != rvc_pkg::SEL_NONE));

endmodule

// File: verilog/rvc_reg_decd.sv
// Register index decode for RV32C
// rs1, rs2 and rd indices with source valid bits
`timescale 1ns/100ps

module rvc_reg_decd
(
    input  rvc_pkg::inst_t    inst,
    output rvc_pkg::reg_idx_t rs1,
    output logic              rs1_vld,
    output rvc_pkg::reg_idx_t rs2,
    output logic              rs2_vld,
    output rvc_pkg::reg_idx_t rd
);

    rvc_pkg::opc_t opc;
    logic          rs2_zero;

    // 3-bit compressed field maps onto x8..x15
    function automatic rvc_pkg::reg_idx_t creg(input logic [2:0] field);
        creg = {2'b01, field};
    endfunction

    assign opc      = {inst[15:13], inst[1:0]};
    assign rs2_zero = (inst[6:2] == 5'd0);

    // ================================================
    // Source 1
    always_comb
    begin
        rs1_vld = 1'b1;
        case (opc)
            rvc_pkg::OPC_LI:       rs1 = rvc_pkg::REG_ZERO;
            rvc_pkg::OPC_LUI:      // C.ADDI16SP when rd is sp
                rs1 = (inst[11:7] == rvc_pkg::REG_SP) ? rvc_pkg::REG_SP : rvc_pkg::REG_ZERO;
            rvc_pkg::OPC_ADDI4SPN,
            rvc_pkg::OPC_LWSP,
            rvc_pkg::OPC_SWSP:     rs1 = rvc_pkg::REG_SP;
            rvc_pkg::OPC_LW,
            rvc_pkg::OPC_SW,
            rvc_pkg::OPC_BEQZ,
            rvc_pkg::OPC_BNEZ,
            rvc_pkg::OPC_MISC_ALU: rs1 = creg(inst[9:7]);
            rvc_pkg::OPC_ADDI,
            rvc_pkg::OPC_SLLI:     rs1 = inst[11:7];
            rvc_pkg::OPC_JR_MV:    // C.MV reads x0 as rs1
                rs1 = (!inst[12] && !rs2_zero) ? rvc_pkg::REG_ZERO : inst[11:7];
            default:
            begin
                rs1_vld = 1'b0;
                rs1     = rvc_pkg::REG_ZERO;
            end
        endcase
    end

    // ================================================
    // Source 2
    always_comb
    begin
        rs2_vld = 1'b1;
        case (opc)
            rvc_pkg::OPC_SWSP,
            rvc_pkg::OPC_JR_MV:    rs2 = inst[6:2];
            rvc_pkg::OPC_SW:       rs2 = creg(inst[4:2]);
            rvc_pkg::OPC_MISC_ALU:
            begin
                rs2_vld = (inst[11:10] == 2'b11);   // Reg-reg forms only
                rs2     = creg(inst[4:2]);
            end
            rvc_pkg::OPC_BEQZ,
            rvc_pkg::OPC_BNEZ:     rs2 = rvc_pkg::REG_ZERO;
            default:
            begin
                rs2_vld = 1'b0;
                rs2     = rvc_pkg::REG_ZERO;
            end
        endcase
    end

    // ================================================
    // Destination
    always_comb
    begin
        case (opc)
            rvc_pkg::OPC_JR_MV:    rd = rs2_zero ? rvc_pkg::REG_RA : inst[11:7];
            rvc_pkg::OPC_JAL:      rd = rvc_pkg::REG_RA;
            rvc_pkg::OPC_MISC_ALU: rd = creg(inst[9:7]);
            rvc_pkg::OPC_LW,
            rvc_pkg::OPC_ADDI4SPN: rd = creg(inst[4:2]);
            default:               rd = inst[11:7];    // LWSP, LI, LUI, ADDI, SLLI
        endcase
    end

endmodule

// File: verilog/rvc_imm_gen.sv
// Immediate generation for the nine RV32C formats
// imm1 holds the ALU immediates, imm2 the offsets
`timescale 1ns/100ps

module rvc_imm_gen
(
    input  rvc_pkg::inst_t inst,
    output rvc_pkg::imm_t  imm1,
    output logic           imm1_vld,
    output rvc_pkg::imm_t  imm2,
    output logic           imm2_vld
);

    rvc_pkg::opc_t opc;
    logic          rd_sp;
    rvc_pkg::imm_t ci_imm, cil_imm, cia_imm, ciw_imm;
    rvc_pkg::imm_t cis_imm, cl_imm, css_imm, cb_imm, cj_imm;
    logic          ci_vld, cil_vld, cia_vld, ciw_vld;
    logic          cis_vld, cl_vld, css_vld, cb_vld, cj_vld;

    assign opc   = {inst[15:13], inst[1:0]};
    assign rd_sp = (inst[11:7] == rvc_pkg::REG_SP);

    // ================================================
    // imm1 formats
    // CI: C.ADDI C.LI C.SLLI C.SRLI C.SRAI C.ANDI
    assign ci_vld  = (opc == rvc_pkg::OPC_ADDI) || (opc == rvc_pkg::OPC_LI)
                  || (opc == rvc_pkg::OPC_SLLI)
                  || ((opc == rvc_pkg::OPC_MISC_ALU) && (inst[11:10] != 2'b11));
    assign ci_imm  = {{27{inst[12]}}, inst[6:2]};
    assign cil_vld = (opc == rvc_pkg::OPC_LUI) && !rd_sp;   // C.LUI
    assign cil_imm = {{15{inst[12]}}, inst[6:2], 12'b0};
    assign cia_vld = (opc == rvc_pkg::OPC_LUI) && rd_sp;    // C.ADDI16SP
    assign cia_imm = {{23{inst[12]}}, inst[4:3], inst[5], inst[2], inst[6], 4'b0};
    assign ciw_vld = (opc == rvc_pkg::OPC_ADDI4SPN);
    assign ciw_imm = {22'b0, inst[10:7], inst[12:11], inst[5], inst[6], 2'b0};

    // ================================================
    // imm2 formats
    assign cis_vld = (opc == rvc_pkg::OPC_LWSP);
    assign cis_imm = {24'b0, inst[3:2], inst[12], inst[6:4], 2'b0};
    assign cl_vld  = (opc == rvc_pkg::OPC_LW) || (opc == rvc_pkg::OPC_SW);
    assign cl_imm  = {25'b0, inst[5], inst[12:10], inst[6], 2'b0};
    assign css_vld = (opc == rvc_pkg::OPC_SWSP);
    assign css_imm = {24'b0, inst[8:7], inst[12:9], 2'b0};
    assign cb_vld  = (opc == rvc_pkg::OPC_BEQZ) || (opc == rvc_pkg::OPC_BNEZ);
    assign cb_imm  = {{24{inst[12]}}, inst[6:5], inst[2], inst[11:10], inst[4:3], 1'b0};
    assign cj_vld  = (opc == rvc_pkg::OPC_JAL) || (opc == rvc_pkg::OPC_J);
    assign cj_imm  = {{21{inst[12]}}, inst[8], inst[10:9], inst[6], inst[7], inst[2],
                      inst[11], inst[5:3], 1'b0};

    // One-hot AND-OR merge
    assign imm1_vld = ci_vld | cil_vld | cia_vld | ciw_vld;
    assign imm1     = ({32{ci_vld}} & ci_imm) | ({32{cil_vld}} & cil_imm)
                    | ({32{cia_vld}} & cia_imm) | ({32{ciw_vld}} & ciw_imm);

    assign imm2_vld = cis_vld | cl_vld | css_vld | cb_vld | cj_vld;
    assign imm2     = ({32{cis_vld}} & cis_imm) | ({32{cl_vld}} & cl_imm)
                    | ({32{css_vld}} & css_imm) | ({32{cb_vld}} & cb_imm)
                    | ({32{cj_vld}} & cj_imm);

    // No format feeds both immediates
    a_imm_excl: assert property (@(inst) !(imm1_vld && imm2_vld));

endmodule

// File: verilog/rvc_decd_stage.sv
// Illegal-instruction check for RV32C
// Decode pipeline register, one cycle of latency
`timescale 1ns/100ps

module rvc_decd_stage
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              inst_vld,
    input  rvc_pkg::inst_t    inst,
    input  rvc_pkg::sel_t     decd_sel,
    input  rvc_pkg::func_t    decd_func,
    input  rvc_pkg::reg_idx_t decd_rs1,
    input  logic              decd_rs1_vld,
    input  rvc_pkg::reg_idx_t decd_rs2,
    input  logic              decd_rs2_vld,
    input  rvc_pkg::reg_idx_t decd_rd,
    input  logic              decd_rd_vld,
    input  rvc_pkg::imm_t     decd_imm1,
    input  logic              decd_imm1_vld,
    input  rvc_pkg::imm_t     decd_imm2,
    input  logic              decd_imm2_vld,
    output logic              dec_vld,
    output rvc_pkg::sel_t     sel,
    output rvc_pkg::func_t    func,
    output rvc_pkg::reg_idx_t rs1,
    output logic              rs1_vld,
    output rvc_pkg::reg_idx_t rs2,
    output logic              rs2_vld,
    output rvc_pkg::reg_idx_t rd,
    output logic              rd_vld,
    output rvc_pkg::imm_t     imm1,
    output logic              imm1_vld,
    output rvc_pkg::imm_t     imm2,
    output logic              imm2_vld,
    output logic              ill_expt
);

    rvc_pkg::opc_t opc;
    logic          ill;

    assign opc = {inst[15:13], inst[1:0]};

    // ================================================
    // Legality table, FP and reserved keys hit default
    always_comb
    begin
        case (opc)
            rvc_pkg::OPC_ADDI4SPN: ill = (inst[12:5] == 8'd0);
            rvc_pkg::OPC_LUI:      ill = ({inst[12], inst[6:2]} == 6'd0);
            rvc_pkg::OPC_SLLI:     ill = inst[12];
            // Shifts with bit 12, and the RV64 reg-reg half
            rvc_pkg::OPC_MISC_ALU: ill = inst[12] && (inst[11:10] != 2'b10);
            rvc_pkg::OPC_LWSP:     ill = (decd_rd == rvc_pkg::REG_ZERO);
            rvc_pkg::OPC_JR_MV:    ill = !inst[12] && (inst[11:2] == 10'd0);
            rvc_pkg::OPC_LW,
            rvc_pkg::OPC_SW,
            rvc_pkg::OPC_ADDI,
            rvc_pkg::OPC_JAL,
            rvc_pkg::OPC_LI,
            rvc_pkg::OPC_J,
            rvc_pkg::OPC_BEQZ,
            rvc_pkg::OPC_BNEZ,
            rvc_pkg::OPC_SWSP:     ill = 1'b0;
            default:               ill = 1'b1;
        endcase
    end

    // ================================================
    // Output register
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dec_vld <= 1'b0;
            {sel, func, rs1, rs1_vld, rs2, rs2_vld, rd, rd_vld,
             imm1, imm1_vld, imm2, imm2_vld, ill_expt} <= '0;
        end
        else
        begin
            dec_vld <= inst_vld;
            if (inst_vld)   // Fields hold while idle
            begin
                {sel, func, rs1, rs1_vld, rs2, rs2_vld, rd, rd_vld,
                 imm1, imm1_vld, imm2, imm2_vld, ill_expt} <=
                    {decd_sel, decd_func, decd_rs1, decd_rs1_vld, decd_rs2, decd_rs2_vld,
                     decd_rd, decd_rd_vld, decd_imm1, decd_imm1_vld, decd_imm2,
                     decd_imm2_vld, ill};
            end
        end
    end

    a_dec_vld_known: assert property (@(posedge clk) disable iff (!arst_n)
                                      !$isunknown(dec_vld));

endmodule

// File: verilog/rvc_decoder.sv
// RV32C decoder top level
// Parallel field decoders feeding one output register
`timescale 1ns/100ps

module rvc_decoder
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              inst_vld,
    input  rvc_pkg::inst_t    inst,
    output logic              dec_vld,
    output rvc_pkg::sel_t     sel,
    output rvc_pkg::func_t    func,
    output rvc_pkg::reg_idx_t rs1,
    output rvc_pkg::reg_idx_t rs2,
    output rvc_pkg::reg_idx_t rd,
    output logic              rs1_vld,
    output logic              rs2_vld,
    output logic              rd_vld,
    output rvc_pkg::imm_t     imm1,
    output rvc_pkg::imm_t     imm2,
    output logic              imm1_vld,
    output logic              imm2_vld,
    output logic              ill_expt
);

    // Unregistered decode results
    rvc_pkg::sel_t     decd_sel;
    rvc_pkg::func_t    decd_func;
    rvc_pkg::reg_idx_t decd_rs1, decd_rs2, decd_rd;
    logic              decd_rs1_vld, decd_rs2_vld, decd_rd_vld;
    rvc_pkg::imm_t     decd_imm1, decd_imm2;
    logic              decd_imm1_vld, decd_imm2_vld;

    rvc_unit_decd u_unit_decd
    (
        .inst(inst), .sel(decd_sel), .func(decd_func), .rd_vld(decd_rd_vld)
    );

    rvc_reg_decd u_reg_decd
    (
        .inst(inst),
        .rs1(decd_rs1), .rs1_vld(decd_rs1_vld),
        .rs2(decd_rs2), .rs2_vld(decd_rs2_vld),
        .rd(decd_rd)
    );

    rvc_imm_gen u_imm_gen
    (
        .inst(inst),
        .imm1(decd_imm1), .imm1_vld(decd_imm1_vld),
        .imm2(decd_imm2), .imm2_vld(decd_imm2_vld)
    );

    rvc_decd_stage u_decd_stage
    (
        .clk(clk), .arst_n(arst_n), .inst_vld(inst_vld), .inst(inst),
        .decd_sel(decd_sel), .decd_func(decd_func),
        .decd_rs1(decd_rs1), .decd_rs1_vld(decd_rs1_vld),
        .decd_rs2(decd_rs2), .decd_rs2_vld(decd_rs2_vld),
        .decd_rd(decd_rd), .decd_rd_vld(decd_rd_vld),
        .decd_imm1(decd_imm1), .decd_imm1_vld(decd_imm1_vld),
        .decd_imm2(decd_imm2), .decd_imm2_vld(decd_imm2_vld),
        .dec_vld(dec_vld), .sel(sel), .func(func),
        .rs1(rs1), .rs1_vld(rs1_vld), .rs2(rs2), .rs2_vld(rs2_vld),
        .rd(rd), .rd_vld(rd_vld),
        .imm1(imm1), .imm1_vld(imm1_vld), .imm2(imm2), .imm2_vld(imm2_vld),
        .ill_expt(ill_expt)
    );

endmodule

// File: tests/tb_rvc_decoder.sv
// Testbench for the RV32C decoder
// Directed tests per instruction group, illegal forms, streaming C.ADDI
`timescale 1ns/100ps

module tb_rvc_decoder;

    logic              clk;
    logic              arst_n;
    logic              inst_vld;
    rvc_pkg::inst_t    inst;
    logic              dec_vld;
    rvc_pkg::sel_t     sel;
    rvc_pkg::func_t    func;
    rvc_pkg::reg_idx_t rs1, rs2, rd;
    logic              rs1_vld, rs2_vld, rd_vld;
    rvc_pkg::imm_t     imm1, imm2;
    logic              imm1_vld, imm2_vld;
    logic              ill_expt;

    integer seed = 32'hc2d2_e3d4;
    int     err_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    rvc_decoder dut0
    (
        .clk(clk), .arst_n(arst_n), .inst_vld(inst_vld), .inst(inst),
        .dec_vld(dec_vld), .sel(sel), .func(func),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .rs1_vld(rs1_vld), .rs2_vld(rs2_vld), .rd_vld(rd_vld),
        .imm1(imm1), .imm2(imm2), .imm1_vld(imm1_vld), .imm2_vld(imm2_vld),
        .ill_expt(ill_expt)
    );

    always #2 clk = ~clk;

    // ================================================
    // Instruction encoders, C-extension bit layouts
    function automatic rvc_pkg::inst_t ci_word(input logic [2:0] f3, input logic [4:0] r,
                                               input logic [31:0] v, input logic [1:0] q);
        ci_word = {f3, v[5], r, v[4:0], q};
    endfunction

    function automatic rvc_pkg::inst_t addi16sp_word(input logic [31:0] v);
        addi16sp_word = {3'b011, v[9], 5'd2, v[4], v[6], v[8:7], v[5], 2'b01};
    endfunction

    function automatic rvc_pkg::inst_t ciw_word(input logic [2:0] rdp, input logic [31:0] v);
        ciw_word = {3'b000, v[5:4], v[9:6], v[2], v[3], rdp, 2'b00};
    endfunction

    function automatic rvc_pkg::inst_t cl_word(input logic [2:0] f3, input logic [2:0] rs1p,
                                               input logic [2:0] rp, input logic [31:0] v);
        cl_word = {f3, v[5:3], rs1p, v[2], v[6], rp, 2'b00};
    endfunction

    function automatic rvc_pkg::inst_t lwsp_word(input logic [4:0] r, input logic [31:0] v);
        lwsp_word = {3'b010, v[5], r, v[4:2], v[7:6], 2'b10};
    endfunction

    function automatic rvc_pkg::inst_t swsp_word(input logic [4:0] r, input logic [31:0] v);
        swsp_word = {3'b110, v[5:2], v[7:6], r, 2'b10};
    endfunction

    function automatic rvc_pkg::inst_t cb_word(input logic [2:0] f3, input logic [2:0] rs1p,
                                               input logic [31:0] v);
        cb_word = {f3, v[8], v[4:3], rs1p, v[7:6], v[2:1], v[5], 2'b01};
    endfunction

    function automatic rvc_pkg::inst_t cj_word(input logic [2:0] f3, input logic [31:0] v);
        cj_word = {f3, v[11], v[4], v[9:8], v[10], v[6], v[7], v[3:1], v[5], 2'b01};
    endfunction

    function automatic rvc_pkg::inst_t cr_word(input logic [3:0] f4, input logic [4:0] r,
                                               input logic [4:0] r2);
        cr_word = {f4, r, r2, 2'b10};
    endfunction

    // ================================================
    // Drive, wait and compare helpers
    task automatic compare_field(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // One strobe, then wait for the registered result
    task automatic apply_inst(input string name, input rvc_pkg::inst_t ins);
        int cnt;
        @(negedge clk);
        inst     = ins;
        inst_vld = 1'b1;
        @(negedge clk);
        inst_vld = 1'b0;
        cnt = 0;
        while (!dec_vld && cnt < 10)
        begin
            @(negedge clk);
            cnt++;
        end
        if (!dec_vld)
        begin
            $display("timeout: no decode result for %s", name);
            err_count++;
        end
    endtask

    // Valids are {rs1, rs2, rd} and {imm1, imm2}; a field counts only when valid
    task automatic expect_decode(input string name, input rvc_pkg::inst_t ins,
                                 input rvc_pkg::sel_t e_sel, input rvc_pkg::func_t e_func,
                                 input logic [2:0] e_vld, input rvc_pkg::reg_idx_t e_rs1,
                                 input rvc_pkg::reg_idx_t e_rs2, input rvc_pkg::reg_idx_t e_rd,
                                 input logic [1:0] e_ivld, input rvc_pkg::imm_t e_imm1,
                                 input rvc_pkg::imm_t e_imm2);
        apply_inst(name, ins);
        compare_field({name, " sel"}, 32'(sel), 32'(e_sel));
        compare_field({name, " func"}, 32'(func), 32'(e_func));
        compare_field({name, " reg valids"}, 32'({rs1_vld, rs2_vld, rd_vld}), 32'(e_vld));
        if (e_vld[2])
            compare_field({name, " rs1"}, 32'(rs1), 32'(e_rs1));
        if (e_vld[1])
            compare_field({name, " rs2"}, 32'(rs2), 32'(e_rs2));
        if (e_vld[0])
            compare_field({name, " rd"}, 32'(rd), 32'(e_rd));
        compare_field({name, " imm valids"}, 32'({imm1_vld, imm2_vld}), 32'(e_ivld));
        if (e_ivld[1])
            compare_field({name, " imm1"}, imm1, e_imm1);
        if (e_ivld[0])
            compare_field({name, " imm2"}, imm2, e_imm2);
        compare_field({name, " ill_expt"}, 32'(ill_expt), 32'd0);
    endtask

    task automatic expect_illegal(input string name, input rvc_pkg::inst_t ins,
                                  input logic no_unit);
        apply_inst(name, ins);
        compare_field({name, " ill_expt"}, 32'(ill_expt), 32'd1);
        if (no_unit)    // Dropped FP forms
        begin
            compare_field({name, " sel"}, 32'(sel), 32'(rvc_pkg::SEL_NONE));
            compare_field({name, " func"}, 32'(func), 32'(rvc_pkg::FUNC_NONE));
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before)
            $display("test %s: ok", name);
        else
        begin
            $display("test %s: %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    // ================================================
    // Directed tests
    task automatic reset_phase();
        int errs;
        int i;
        errs = err_count;
        arst_n = 1'b0;
        for (i = 0; i < 4; i++)
        begin
            @(negedge clk);
            compare_field("reset dec_vld", 32'(dec_vld), 32'd0);
        end
        arst_n = 1'b1;
        @(negedge clk);    // Released, no strobe yet
        compare_field("idle dec_vld", 32'(dec_vld), 32'd0);
        compare_field("idle sel", 32'(sel), 32'd0);
        compare_field("idle imm1", imm1, 32'd0);
        compare_field("idle ill_expt", 32'(ill_expt), 32'd0);
        report_test("reset", errs);
    endtask

    task automatic alu_group();
        int errs;
        errs = err_count;
        expect_decode("c.addi", ci_word(3'b000, 5'd5, -3, 2'b01), rvc_pkg::SEL_ALU,
                      rvc_pkg::FUNC_ADD, 3'b101, 5'd5, 5'd0, 5'd5, 2'b10, -3, 0);
        expect_decode("c.li", ci_word(3'b010, 5'd10, 17, 2'b01), rvc_pkg::SEL_ALU,
                      rvc_pkg::FUNC_ADD, 3'b101, 5'd0, 5'd0, 5'd10, 2'b10, 17, 0);
        expect_decode("c.lui", ci_word(3'b011, 5'd7, -31, 2'b01), rvc_pkg::SEL_ALU,
                      rvc_pkg::FUNC_ADD, 3'b101, 5'd0, 5'd0, 5'd7, 2'b10, -31 * 4096, 0);
        expect_decode("c.addi16sp", addi16sp_word(-80), rvc_pkg::SEL_ALU,
                      rvc_pkg::FUNC_ADD, 3'b101, 5'd2, 5'd0, 5'd2, 2'b10, -80, 0);
        expect_decode("c.addi4spn", ciw_word(3'd1, 676), rvc_pkg::SEL_ALU,
                      rvc_pkg::FUNC_ADD, 3'b101, 5'd2, 5'd0, 5'd9, 2'b10, 676, 0);
        expect_decode("c.sub", {3'b100, 1'b0, 2'b11, 3'd4, 2'b00, 3'd5, 2'b01},
                      rvc_pkg::SEL_ALU, rvc_pkg::FUNC_SUB, 3'b111, 5'd12, 5'd13, 5'd12,
                      2'b00, 0, 0);
        expect_decode("c.srai", {3'b100, 1'b0, 2'b01, 3'd6, 5'd7, 2'b01},
                      rvc_pkg::SEL_ALU, rvc_pkg::FUNC_SRA, 3'b101, 5'd14, 5'd0, 5'd14,
                      2'b10, 7, 0);
        expect_decode("c.slli", ci_word(3'b000, 5'd20, 13, 2'b10), rvc_pkg::SEL_ALU,
                      rvc_pkg::FUNC_SLL, 3'b101, 5'd20, 5'd0, 5'd20, 2'b10, 13, 0);
        expect_decode("c.and", {3'b100, 1'b0, 2'b11, 3'd0, 2'b11, 3'd7, 2'b01},
                      rvc_pkg::SEL_ALU, rvc_pkg::FUNC_AND, 3'b111, 5'd8, 5'd15, 5'd8,
                      2'b00, 0, 0);
        expect_decode("c.mv", cr_word(4'b1000, 5'd6, 5'd11), rvc_pkg::SEL_ALU,
                      rvc_pkg::FUNC_ADD, 3'b111, 5'd0, 5'd11, 5'd6, 2'b00, 0, 0);
        report_test("alu group", errs);
    endtask

    task automatic bju_group();
        int errs;
        errs = err_count;
        expect_decode("c.jal", cj_word(3'b001, -1446), rvc_pkg::SEL_BJU,
                      rvc_pkg::FUNC_JAL, 3'b001, 5'd0, 5'd0, 5'd1, 2'b01, 0, -1446);
        expect_decode("c.j", cj_word(3'b101, 1022), rvc_pkg::SEL_BJU,
                      rvc_pkg::FUNC_JAL, 3'b000, 5'd0, 5'd0, 5'd0, 2'b01, 0, 1022);
        expect_decode("c.beqz", cb_word(3'b110, 3'd2, -100), rvc_pkg::SEL_BJU,
                      rvc_pkg::FUNC_BEQ, 3'b110, 5'd10, 5'd0, 5'd0, 2'b01, 0, -100);
        expect_decode("c.bnez", cb_word(3'b111, 3'd7, 86), rvc_pkg::SEL_BJU,
                      rvc_pkg::FUNC_BNE, 3'b110, 5'd15, 5'd0, 5'd0, 2'b01, 0, 86);
        // CR forms read the rs2 field, which is x0 here
        expect_decode("c.jr", cr_word(4'b1000, 5'd9, 5'd0), rvc_pkg::SEL_BJU,
                      rvc_pkg::FUNC_JALR, 3'b110, 5'd9, 5'd0, 5'd0, 2'b00, 0, 0);
        expect_decode("c.jalr", cr_word(4'b1001, 5'd13, 5'd0), rvc_pkg::SEL_BJU,
                      rvc_pkg::FUNC_JALR, 3'b111, 5'd13, 5'd0, 5'd1, 2'b00, 0, 0);
        expect_decode("c.ebreak", cr_word(4'b1001, 5'd0, 5'd0), rvc_pkg::SEL_CP0,
                      rvc_pkg::FUNC_EBREAK, 3'b110, 5'd0, 5'd0, 5'd0, 2'b00, 0, 0);
        report_test("bju group", errs);
    endtask

    task automatic lsu_group();
        int errs;
        errs = err_count;
        expect_decode("c.lw", cl_word(3'b010, 3'd1, 3'd3, 84), rvc_pkg::SEL_LSU,
                      rvc_pkg::FUNC_LW, 3'b101, 5'd9, 5'd0, 5'd11, 2'b01, 0, 84);
        expect_decode("c.sw", cl_word(3'b110, 3'd0, 3'd6, 124), rvc_pkg::SEL_LSU,
                      rvc_pkg::FUNC_SW, 3'b110, 5'd8, 5'd14, 5'd0, 2'b01, 0, 124);
        expect_decode("c.lwsp", lwsp_word(5'd18, 180), rvc_pkg::SEL_LSU,
                      rvc_pkg::FUNC_LW, 3'b101, 5'd2, 5'd0, 5'd18, 2'b01, 0, 180);
        expect_decode("c.swsp", swsp_word(5'd25, 232), rvc_pkg::SEL_LSU,
                      rvc_pkg::FUNC_SW, 3'b110, 5'd2, 5'd25, 5'd0, 2'b01, 0, 232);
        report_test("lsu group", errs);
    endtask

    task automatic illegal_forms();
        int errs;
        errs = err_count;
        expect_illegal("all zero", 16'h0000, 1'b0);
        expect_illegal("c.lwsp rd zero", lwsp_word(5'd0, 8), 1'b0);
        expect_illegal("c.slli bit 12", ci_word(3'b000, 5'd3, 33, 2'b10), 1'b0);
        expect_illegal("c.jr rs1 zero", cr_word(4'b1000, 5'd0, 5'd0), 1'b0);
        expect_illegal("c.flw", cl_word(3'b011, 3'd1, 3'd2, 8), 1'b1);
        expect_illegal("c.lui zero imm", ci_word(3'b011, 5'd5, 0, 2'b01), 1'b0);
        report_test("illegal", errs);
    endtask

    // Back-to-back C.ADDI, each result exactly one cycle after its strobe
    task automatic stream_addi();
        rvc_pkg::reg_idx_t q_rd[$];
        rvc_pkg::imm_t     q_imm[$];
        rvc_pkg::reg_idx_t r;
        rvc_pkg::reg_idx_t exp_rd;
        rvc_pkg::imm_t     exp_imm;
        logic [5:0]        v;
        int                errs;
        int                i;
        errs = err_count;
        for (i = 0; i <= 32; i++)
        begin
            @(negedge clk);
            if (i > 0)
            begin
                exp_rd  = q_rd.pop_front();
                exp_imm = q_imm.pop_front();
                if (!dec_vld)
                begin
                    $display("stream result %0d did not arrive one cycle after input", i - 1);
                    err_count++;
                end
                compare_field("stream rd", 32'(rd), 32'(exp_rd));
                compare_field("stream rs1", 32'(rs1), 32'(exp_rd));
                compare_field("stream imm1", imm1, exp_imm);
            end
            if (i < 32)
            begin
                r        = 5'($random(seed));
                v        = 6'($random(seed));
                inst     = {3'b000, v[5], r, v[4:0], 2'b01};
                inst_vld = 1'b1;
                q_rd.push_back(r);
                q_imm.push_back({{26{v[5]}}, v});
            end
            else
                inst_vld = 1'b0;
        end
        @(negedge clk);
        if (dec_vld)
        begin
            $display("dec_vld stayed high after the stream ended");
            err_count++;
        end
        report_test("stream", errs);
    endtask

    // ================================================
    // Main sequence
    initial
    begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        inst_vld = 1'b0;
        inst     = '0;
        reset_phase();
        alu_group();
        bju_group();
        lsu_group();
        illegal_forms();
        stream_addi();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: compile.f
verilog/rvc_pkg.sv
verilog/rvc_unit_decd.sv
verilog/rvc_reg_decd.sv
verilog/rvc_imm_gen.sv
verilog/rvc_decd_stage.sv
verilog/rvc_decoder.sv
tests/tb_rvc_decoder.sv

// File: run.sh
#!/bin/sh
# Build the RV32C decoder testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rvc_decoder \
    -f compile.f \
    -o sim_rvc_decoder
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_rvc_decoder)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
